/* Makefile */
# run with: make simulate NUM_ROUNDS=14 for standard BLAKE-256
VERILATOR  ?= verilator
NUM_ROUNDS ?= 8
TOP        ?= blake256_tb
FILELIST   ?= blake256_top.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GNUM_ROUNDS=$(NUM_ROUNDS) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* blake256_top.f */
rtl/blake_pkg.sv
rtl/blake_g.sv
rtl/blake_init.sv
rtl/blake_round.sv
rtl/blake_final.sv
rtl/blake256_top.sv
+incdir+verification
verification/blake256_sva.sv
verification/blake256_tb.sv

/* rtl/blake256_top.sv */
// BLAKE-256 compression pipeline, takes one block per clock with no back-pressure
// results come out in input order 2*NUM_ROUNDS+2 cycles after each accepted block
`timescale 1ns/1ps

module blake256_top #(
   parameter int NUM_ROUNDS = blake_pkg::DEFAULT_ROUNDS
) (
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic                in_valid_i,
   input  blake_pkg::chain_t   chain_i,
   input  blake_pkg::block_t   block_i,
   input  blake_pkg::counter_t counter_i,
   output logic                out_valid_o,
   output blake_pkg::chain_t   hash_o
);

   // slot 0 comes from the initialiser, slot k+1 from round k
   blake_pkg::stage_t stage_s [NUM_ROUNDS + 1];

   blake_init u_init (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .in_valid_i (in_valid_i),
      .chain_i    (chain_i),
      .block_i    (block_i),
      .counter_i  (counter_i),
      .stage_o    (stage_s[0])
   );

   for (genvar r = 0; r < NUM_ROUNDS; r++) begin : g_round
      blake_round #(
         .ROUND_INDEX (r)
      ) u_round (
         .clk     (clk),
         .rst_n_i (rst_n_i),
         .stage_i (stage_s[r]),
         .stage_o (stage_s[r + 1])
      );
   end

   blake_final u_final (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .stage_i     (stage_s[NUM_ROUNDS]),
      .out_valid_o (out_valid_o),
      .hash_o      (hash_o)
   );

endmodule

/* rtl/blake_final.sv */
// last pipeline stage, folds the working state back into the chain value
// the new chain value leaves through a register together with its valid bit
`timescale 1ns/1ps

module blake_final (
   input  logic              clk,
   input  logic              rst_n_i,
   input  blake_pkg::stage_t stage_i,
   output logic              out_valid_o,
   output blake_pkg::chain_t hash_o
);

   blake_pkg::chain_t hash_d;
   blake_pkg::chain_t hash_q;
   logic              valid_q;

   // salt is zero, so each word is just h_i ^ v_i ^ v_i+8
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         hash_d[i] = stage_i.h[i] ^ stage_i.v[i] ^ stage_i.v[i + 8];
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= stage_i.valid;
      end
   end

   always_ff @(posedge clk) begin
      hash_q <= hash_d;
   end

   assign out_valid_o = valid_q;
   assign hash_o      = hash_q;

endmodule

/* rtl/blake_g.sv */
// combinational G mixing function on one column or diagonal of the state
// the message inputs arrive already XORed with their paired constants
`timescale 1ns/1ps

module blake_g (
   input  blake_pkg::word_t a_i,
   input  blake_pkg::word_t b_i,
   input  blake_pkg::word_t c_i,
   input  blake_pkg::word_t d_i,
   input  blake_pkg::word_t mx_i,
   input  blake_pkg::word_t my_i,
   output blake_pkg::word_t a_o,
   output blake_pkg::word_t b_o,
   output blake_pkg::word_t c_o,
   output blake_pkg::word_t d_o
);

   function automatic blake_pkg::word_t rotr(input blake_pkg::word_t x, input int unsigned n);
      rotr = (x >> n) | (x << (32 - n));
   endfunction

   blake_pkg::word_t a1, b1, c1, d1;

   // first half-step mixes in mx_i
   assign a1 = a_i + b_i + mx_i;
   assign d1 = rotr(d_i ^ a1, blake_pkg::ROT_A);
   assign c1 = c_i + d1;
   assign b1 = rotr(b_i ^ c1, blake_pkg::ROT_B);

   // second half-step mixes in my_i
   assign a_o = a1 + b1 + my_i;
   assign d_o = rotr(d1 ^ a_o, blake_pkg::ROT_C);
   assign c_o = c1 + d_o;
   assign b_o = rotr(b1 ^ c_o, blake_pkg::ROT_D);

endmodule

/* rtl/blake_init.sv */
// first pipeline stage that loads the 16-word working state from chain value and counter
// the message and chain value are carried along for the rounds and the feed-forward
`timescale 1ns/1ps

module blake_init (
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic                in_valid_i,
   input  blake_pkg::chain_t   chain_i,
   input  blake_pkg::block_t   block_i,
   input  blake_pkg::counter_t counter_i,
   output blake_pkg::stage_t   stage_o
);

   blake_pkg::state_t init_v;
   logic              valid_q;
   blake_pkg::state_t v_q;
   blake_pkg::block_t m_q;
   blake_pkg::chain_t h_q;

   always_comb begin
      // v0 to v7 start from the chain value
      for (int i = 0; i < 8; i++) begin
         init_v[i] = chain_i[i];
      end
      for (int i = 0; i < 4; i++) begin
         init_v[8 + i] = blake_pkg::BLAKE_CONST[i];
      end
      // salt is zero, so only the counter words are mixed in
      init_v[12] = blake_pkg::BLAKE_CONST[4] ^ counter_i[31:0];
      init_v[13] = blake_pkg::BLAKE_CONST[5] ^ counter_i[31:0];
      init_v[14] = blake_pkg::BLAKE_CONST[6] ^ counter_i[63:32];
      init_v[15] = blake_pkg::BLAKE_CONST[7] ^ counter_i[63:32];
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= in_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      v_q <= init_v;
      m_q <= block_i;
      h_q <= chain_i;
   end

   assign stage_o = '{valid: valid_q, v: v_q, m: m_q, h: h_q};

endmodule

/* rtl/blake_pkg.sv */
// shared types and constant tables for the BLAKE-256 compression pipeline
// modules and the testbench reach these through blake_pkg:: scoped names
package blake_pkg;

   typedef logic [31:0] word_t;

   // word i of each array sits at bits [32*i+31:32*i], so index 0 is v0, m0 or h0
   typedef word_t [15:0] state_t;
   typedef word_t [15:0] block_t;
   typedef word_t [7:0]  chain_t;

   // t0 is the low word and t1 the high word
   typedef logic [63:0] counter_t;

   // one pipeline slot, handed from stage to stage every clock
   typedef struct packed {
      logic   valid;
      state_t v;
      block_t m;
      chain_t h;
   } stage_t;

   // c0 is the right-most word
   localparam word_t [15:0] BLAKE_CONST = {
      32'hB5470917, 32'h3F84D5B5, 32'hC97C50DD, 32'hC0AC29B7,
      32'h34E90C6C, 32'hBE5466CF, 32'h38D01377, 32'h452821E6,
      32'hEC4E6C89, 32'h082EFA98, 32'h299F31D0, 32'hA4093822,
      32'h03707344, 32'h13198A2E, 32'h85A308D3, 32'h243F6A88
   };

   // one permutation row, entry i is nibble i counted from the right
   typedef logic [15:0][3:0] sigma_row_t;

   // row 0 is the identity, reading the hex right to left gives sigma_r(0..15)
   localparam sigma_row_t SIGMA [10] = '{
      64'hFEDCBA9876543210,
      64'h357B20C16DF984AE,
      64'h491763EADF250C8B,
      64'h8F04A562EBCD1397,
      64'hD386CB1EFA427509,
      64'h91EF57D438B0A6C2,
      64'hB8293670A4DEF15C,
      64'hA2684F05931CE7BD,
      64'h5A417D2C803B9EF6,
      64'h0DC3E9BF5167482A
   };

   // right rotations of the two G half-steps
   localparam int unsigned ROT_A = 16;
   localparam int unsigned ROT_B = 12;
   localparam int unsigned ROT_C = 8;
   localparam int unsigned ROT_D = 7;

   // reduced-round variant, 14 gives standard BLAKE-256
   localparam int DEFAULT_ROUNDS = 8;

endpackage

/* rtl/blake_round.sv */
// one BLAKE round as two pipeline stages, column step then diagonal step
// ROUND_INDEX picks the sigma row, wrapping after ten rounds
`timescale 1ns/1ps

module blake_round #(
   parameter int ROUND_INDEX = 0
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  blake_pkg::stage_t stage_i,
   output blake_pkg::stage_t stage_o
);

   localparam blake_pkg::sigma_row_t SROW = blake_pkg::SIGMA[ROUND_INDEX % 10];

   blake_pkg::state_t col_v;
   blake_pkg::state_t diag_v;

   logic              mid_valid_q;
   blake_pkg::state_t mid_v_q;
   blake_pkg::block_t mid_m_q;
   blake_pkg::chain_t mid_h_q;

   logic              out_valid_q;
   blake_pkg::state_t out_v_q;
   blake_pkg::block_t out_m_q;
   blake_pkg::chain_t out_h_q;

   // G0..G3 work on the columns (v_i, v_4+i, v_8+i, v_12+i)
   for (genvar i = 0; i < 4; i++) begin : g_col
      localparam int SX = SROW[2 * i];
      localparam int SY = SROW[2 * i + 1];

      blake_g u_g (
         .a_i  (stage_i.v[i]),
         .b_i  (stage_i.v[4 + i]),
         .c_i  (stage_i.v[8 + i]),
         .d_i  (stage_i.v[12 + i]),
         .mx_i (stage_i.m[SX] ^ blake_pkg::BLAKE_CONST[SY]),
         .my_i (stage_i.m[SY] ^ blake_pkg::BLAKE_CONST[SX]),
         .a_o  (col_v[i]),
         .b_o  (col_v[4 + i]),
         .c_o  (col_v[8 + i]),
         .d_o  (col_v[12 + i])
      );
   end

   // G4..G7 take the diagonals, G4 is (v0, v5, v10, v15) and the rest shift along
   for (genvar i = 0; i < 4; i++) begin : g_diag
      localparam int SX = SROW[8 + 2 * i];
      localparam int SY = SROW[9 + 2 * i];
      localparam int IB = 4 + ((i + 1) % 4);
      localparam int IC = 8 + ((i + 2) % 4);
      localparam int ID = 12 + ((i + 3) % 4);

      blake_g u_g (
         .a_i  (mid_v_q[i]),
         .b_i  (mid_v_q[IB]),
         .c_i  (mid_v_q[IC]),
         .d_i  (mid_v_q[ID]),
         .mx_i (mid_m_q[SX] ^ blake_pkg::BLAKE_CONST[SY]),
         .my_i (mid_m_q[SY] ^ blake_pkg::BLAKE_CONST[SX]),
         .a_o  (diag_v[i]),
         .b_o  (diag_v[IB]),
         .c_o  (diag_v[IC]),
         .d_o  (diag_v[ID])
      );
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mid_valid_q <= 1'b0;
         out_valid_q <= 1'b0;
      end else begin
         mid_valid_q <= stage_i.valid;
         out_valid_q <= mid_valid_q;
      end
   end

   // message and chain value ride along unchanged with the state
   always_ff @(posedge clk) begin
      mid_v_q <= col_v;
      mid_m_q <= stage_i.m;
      mid_h_q <= stage_i.h;
      out_v_q <= diag_v;
      out_m_q <= mid_m_q;
      out_h_q <= mid_h_q;
   end

   assign stage_o = '{valid: out_valid_q, v: out_v_q, m: out_m_q, h: out_h_q};

endmodule

/* verification/blake256_sva.sv */
// concurrent checks on the pipeline top level, attached to it with bind
// covers quiet output in reset, the fixed latency and known result data
`timescale 1ns/1ps

module blake256_sva #(
   parameter int NUM_ROUNDS = blake_pkg::DEFAULT_ROUNDS
) (
   input logic              clk,
   input logic              rst_n_i,
   input logic              in_valid_i,
   input logic              out_valid_o,
   input blake_pkg::chain_t hash_o
);

   localparam int LATENCY = 2 * NUM_ROUNDS + 2;

   reset_quiet: assert property (@(posedge clk) !rst_n_i |-> !out_valid_o)
      else $error("out_valid_o is high while reset is active");

   // every accepted block leaves the pipeline after exactly LATENCY cycles
   fixed_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
      in_valid_i |-> ##LATENCY out_valid_o)
      else $error("no result %0d cycles after an accepted block", LATENCY);

   known_hash: assert property (@(posedge clk) disable iff (!rst_n_i)
      out_valid_o |-> !$isunknown(hash_o))
      else $error("hash_o has unknown bits while out_valid_o is high");

endmodule

bind blake256_top blake256_sva #(
   .NUM_ROUNDS (NUM_ROUNDS)
) u_sva (
   .clk         (clk),
   .rst_n_i     (rst_n_i),
   .in_valid_i  (in_valid_i),
   .out_valid_o (out_valid_o),
   .hash_o      (hash_o)
);

/* verification/blake_ref_model.svh */
// behavioural BLAKE-256 compression function used by the testbench scoreboard
// included inside the testbench module, salt is taken as zero
`ifndef BLAKE_REF_MODEL_SVH
`define BLAKE_REF_MODEL_SVH

function automatic blake_pkg::word_t rotate_right(input blake_pkg::word_t x, input int n);
   return (x >> n) | (x << (32 - n));
endfunction

// one G evaluation on state words a, b, c, d with message terms x and y
function automatic blake_pkg::state_t mix_words(
   input blake_pkg::state_t v_in,
   input int                a,
   input int                b,
   input int                c,
   input int                d,
   input blake_pkg::word_t  x,
   input blake_pkg::word_t  y
);
   blake_pkg::state_t v;
   v = v_in;
   v[a] = v[a] + v[b] + x;
   v[d] = rotate_right(v[d] ^ v[a], 16);
   v[c] = v[c] + v[d];
   v[b] = rotate_right(v[b] ^ v[c], 12);
   v[a] = v[a] + v[b] + y;
   v[d] = rotate_right(v[d] ^ v[a], 8);
   v[c] = v[c] + v[d];
   v[b] = rotate_right(v[b] ^ v[c], 7);
   return v;
endfunction

function automatic blake_pkg::chain_t compress_block(
   input blake_pkg::chain_t   h,
   input blake_pkg::block_t   m,
   input blake_pkg::counter_t t,
   input int                  rounds
);
   blake_pkg::state_t v;
   blake_pkg::chain_t result;
   int                lanes [8][4];
   int                sx;
   int                sy;
   // four columns followed by four diagonals, as in the specification
   lanes = '{'{0, 4, 8, 12}, '{1, 5, 9, 13}, '{2, 6, 10, 14}, '{3, 7, 11, 15},
             '{0, 5, 10, 15}, '{1, 6, 11, 12}, '{2, 7, 8, 13}, '{3, 4, 9, 14}};
   for (int i = 0; i < 8; i++) begin
      v[i]     = h[i];
      v[8 + i] = blake_pkg::BLAKE_CONST[i];
   end
   v[12] = v[12] ^ t[31:0];
   v[13] = v[13] ^ t[31:0];
   v[14] = v[14] ^ t[63:32];
   v[15] = v[15] ^ t[63:32];
   for (int r = 0; r < rounds; r++) begin
      for (int g = 0; g < 8; g++) begin
         sx = int'(blake_pkg::SIGMA[r % 10][2 * g]);
         sy = int'(blake_pkg::SIGMA[r % 10][2 * g + 1]);
         v = mix_words(v, lanes[g][0], lanes[g][1], lanes[g][2], lanes[g][3],
                       m[sx] ^ blake_pkg::BLAKE_CONST[sy], m[sy] ^ blake_pkg::BLAKE_CONST[sx]);
      end
   end
   for (int i = 0; i < 8; i++) begin
      result[i] = h[i] ^ v[i] ^ v[i + 8];
   end
   return result;
endfunction

`endif

/* verification/blake256_tb.sv */
// self-checking testbench for the BLAKE-256 pipeline with LFSR stimulus
// results are compared in order against the behavioural model in a scoreboard queue
`timescale 1ns/1ps

module blake256_tb;

   parameter int NUM_ROUNDS = blake_pkg::DEFAULT_ROUNDS;

   localparam int LATENCY        = 2 * NUM_ROUNDS + 2;
   localparam int RESET_CYCLES   = 8;
   localparam int BURST_CYCLES   = 40;
   localparam int GAP_CYCLES     = 120;
   localparam int COUNTER_CYCLES = 16;
   localparam int STIM_CYCLES    = RESET_CYCLES + BURST_CYCLES + GAP_CYCLES + COUNTER_CYCLES;
   localparam int TIMEOUT_CYCLES = STIM_CYCLES + LATENCY + 20;

   typedef struct packed {
      blake_pkg::chain_t hash;
      logic [31:0]       due_cycle;
   } expect_t;

   logic                clk;
   logic                rst_n_i;
   logic                in_valid_i;
   blake_pkg::chain_t   chain_i;
   blake_pkg::block_t   block_i;
   blake_pkg::counter_t counter_i;
   logic                out_valid_o;
   blake_pkg::chain_t   hash_o;

   logic [31:0] lfsr_state;
   int unsigned cycle_count;
   int unsigned watchdog_count = 0;
   expect_t     expect_q [$];

   `include "blake_ref_model.svh"

   blake256_top #(
      .NUM_ROUNDS (NUM_ROUNDS)
   ) UUT (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (in_valid_i),
      .chain_i     (chain_i),
      .block_i     (block_i),
      .counter_i   (counter_i),
      .out_valid_o (out_valid_o),
      .hash_o      (hash_o)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      watchdog_count <= watchdog_count + 1;
      if (watchdog_count >= TIMEOUT_CYCLES) begin
         $display("run timed out after %0d cycles", watchdog_count);
         $display("Test FAILED");
         $fatal(1, "watchdog expired");
      end
   end

   // Galois form of x^32 + x^22 + x^2 + x + 1, shifting right
   function automatic logic [31:0] step_lfsr(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h80200003;
      end
      return s >> 1;
   endfunction

   task automatic draw_bits(input int n, output logic [511:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = step_lfsr(lfsr_state);
         bits[i]    = lfsr_state[0];
      end
   endtask

   task automatic draw_block_inputs(output blake_pkg::chain_t c, output blake_pkg::block_t b,
                                    output blake_pkg::counter_t t);
      logic [511:0] bits;
      draw_bits(256, bits);
      c = bits[255:0];
      draw_bits(512, bits);
      b = bits;
      draw_bits(64, bits);
      t = bits[63:0];
   endtask

   task automatic check_output();
      expect_t e;
      if (out_valid_o) begin
         assert (expect_q.size() > 0) else begin
            $display("a result appeared at %0t with no block outstanding", $time);
            $display("Test FAILED");
            $fatal(1, "spurious result");
         end
         e = expect_q.pop_front();
         assert (cycle_count == e.due_cycle) else begin
            $display("MISMATCH at %0t: result in cycle %0d, expected in cycle %0d",
                     $time, cycle_count, e.due_cycle);
            $display("Test FAILED");
            $fatal(1, "latency mismatch");
         end
         assert (hash_o == e.hash) else begin
            $display("MISMATCH at %0t: hash_o %h, expected %h", $time, hash_o, e.hash);
            $display("Test FAILED");
            $fatal(1, "hash mismatch");
         end
      end else if (expect_q.size() > 0) begin
         assert (cycle_count < expect_q[0].due_cycle) else begin
            $display("the result due in cycle %0d did not arrive", expect_q[0].due_cycle);
            $display("Test FAILED");
            $fatal(1, "missing result");
         end
      end
   endtask

   // drive on the rising edge, check the registered outputs on the falling edge
   task automatic run_cycle(input logic valid, input blake_pkg::chain_t c,
                            input blake_pkg::block_t b, input blake_pkg::counter_t t);
      expect_t e;
      @(posedge clk);
      cycle_count++;
      rst_n_i    <= (cycle_count > RESET_CYCLES);
      in_valid_i <= valid;
      chain_i    <= c;
      block_i    <= b;
      counter_i  <= t;
      if (valid) begin
         e.hash      = compress_block(c, b, t, NUM_ROUNDS);
         e.due_cycle = cycle_count + LATENCY;
         expect_q.push_back(e);
      end
      @(negedge clk);
      check_output();
   endtask

   initial begin
      blake_pkg::chain_t   c;
      blake_pkg::block_t   b;
      blake_pkg::counter_t t;
      logic [511:0]        bits;
      rst_n_i     = 1'b0;
      in_valid_i  = 1'b0;
      chain_i     = '0;
      block_i     = '0;
      counter_i   = '0;
      lfsr_state  = 32'h8a449ee8;
      cycle_count = 0;
      repeat (RESET_CYCLES) run_cycle(1'b0, '0, '0, '0);
      repeat (BURST_CYCLES) begin
         draw_block_inputs(c, b, t);
         run_cycle(1'b1, c, b, t);
      end
      // about three cycles in four carry a block
      repeat (GAP_CYCLES) begin
         draw_bits(2, bits);
         draw_block_inputs(c, b, t);
         run_cycle(bits[0] | bits[1], c, b, t);
      end
      // same chain value and message, only the counter changes
      repeat (COUNTER_CYCLES) begin
         draw_bits(64, bits);
         t = bits[63:0];
         run_cycle(1'b1, c, b, t);
      end
      repeat (LATENCY + 2) run_cycle(1'b0, c, b, t);
      if (expect_q.size() == 0) begin
         $display("Test OK");
         $finish;
      end else begin
         $display("%0d blocks never produced a result", expect_q.size());
         $display("Test FAILED");
         $fatal(1, "results outstanding");
      end
   end

endmodule
